/* hdl/timer_pkg.sv */
`default_nettype none

package timer_pkg;

    localparam int CNT_W     = 32;
    localparam int INNER_NUM = 4;  // lines from sibling timers.
    localparam int SRC_NUM   = 2 + INNER_NUM;
    localparam int SEL_W     = 3;
    localparam int SLOT_NUM  = 3;

    // routable source indices.
    localparam int SRC_EXT_A  = 0;
    localparam int SRC_EXT_B  = 1;
    localparam int SRC_INNER0 = 2; // inner line k sits at SRC_INNER0 + k.

    typedef logic [CNT_W-1:0] cnt_t;
    typedef logic [SEL_W-1:0] sel_t;
    typedef logic [1:0]       slot_t;

    typedef enum logic [1:0] {
        EDGE_RISE = 2'd0,
        EDGE_FALL = 2'd1,
        EDGE_BOTH = 2'd2,
        EDGE_NONE = 2'd3
    } edge_t;

    typedef enum logic {
        MODE_CAPTURE = 1'b0,
        MODE_WAVE    = 1'b1
    } mode_t;

endpackage

`default_nettype wire

/* hdl/edge_select.sv */
`timescale 1ns/1ns
`default_nettype none

module edge_select (
    input  wire                          i_clk,
    input  wire                          i_rst_n,
    input  wire [timer_pkg::SRC_NUM-1:0] i_src,
    input  wire timer_pkg::sel_t         i_sel,
    input  wire timer_pkg::edge_t        i_edge,
    output logic                         o_hit
);

    logic       src_bit;
    logic [1:0] samp_q;  // [0] newest, [1] previous.
    logic       rise;
    logic       fall;

    always_comb begin
        src_bit = 1'b0; // indices past the last source read low.
        if (int'(i_sel) < timer_pkg::SRC_NUM) begin
            src_bit = i_src[i_sel];
        end
    end

    // two-flop sampling, edges taken between the two stages.
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            samp_q <= 2'b00;
        end else begin
            samp_q <= {samp_q[0], src_bit};
        end
    end

    assign rise = samp_q[0] & ~samp_q[1];
    assign fall = ~samp_q[0] & samp_q[1];

    always_comb begin
        case (i_edge)
            timer_pkg::EDGE_RISE: o_hit = rise;
            timer_pkg::EDGE_FALL: o_hit = fall;
            timer_pkg::EDGE_BOTH: o_hit = rise | fall;
            default:              o_hit = 1'b0; // edge none.
        endcase
    end

    // a floating select would feed x into the run and capture logic.
    a_sel_known: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        !$isunknown(i_sel)
    ) else $error("edge_select: unknown source index");

endmodule

`default_nettype wire

/* hdl/count_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module count_ctrl (
    input  wire                    i_clk,
    input  wire                    i_rst_n,
    input  wire                    i_enable,
    input  wire                    i_soft_start,
    input  wire                    i_soft_stop,
    input  wire                    i_soft_clear,
    input  wire                    i_start_hit,
    input  wire                    i_stop_hit,
    input  wire timer_pkg::mode_t  i_mode,
    input  wire                    i_end_a,
    input  wire                    i_end_b,
    input  wire                    i_stop_at_end_a,
    input  wire                    i_stop_at_end_b,
    output timer_pkg::cnt_t        o_count,
    output logic                   o_running,
    output logic                   o_wave_en,
    output logic                   o_cap_en,
    output logic                   o_clear
);

    logic [2:0] soft_q; // start, stop, clear as last seen.
    logic       soft_start;
    logic       soft_stop;
    logic       soft_clear;
    logic       start_cmd;
    logic       stop_cmd;
    logic       end_stop;
    logic       end_restart;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            soft_q <= 3'b000;
        end else begin
            soft_q <= {i_soft_start, i_soft_stop, i_soft_clear};
        end
    end

    // every level change of a soft line is one command.
    assign soft_start = i_soft_start ^ soft_q[2];
    assign soft_stop  = i_soft_stop ^ soft_q[1];
    assign soft_clear = i_soft_clear ^ soft_q[0];

    assign start_cmd = soft_start | i_start_hit;
    assign stop_cmd  = soft_stop | i_stop_hit;

    assign end_stop    = (i_end_a & i_stop_at_end_a) | (i_end_b & i_stop_at_end_b);
    assign end_restart = (i_end_a & ~i_stop_at_end_a) | (i_end_b & ~i_stop_at_end_b);

    assign o_clear = ~i_enable | soft_clear; // held while disabled.

    // run flag and mode enables.
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_running <= 1'b0;
            o_wave_en <= 1'b0;
            o_cap_en  <= 1'b0;
        end else if (!i_enable || stop_cmd) begin // stop beats start.
            o_running <= 1'b0;
            o_wave_en <= 1'b0;
            o_cap_en  <= 1'b0;
        end else if (start_cmd) begin
            o_running <= 1'b1;
            o_wave_en <= (i_mode == timer_pkg::MODE_WAVE);
            o_cap_en  <= (i_mode == timer_pkg::MODE_CAPTURE);
        end else if (end_stop) begin
            o_running <= 1'b0;
            o_wave_en <= 1'b0;
            o_cap_en  <= 1'b0;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_count <= '0;
        end else if (o_clear) begin
            o_count <= '0;
        end else if (o_running && !stop_cmd && !end_stop) begin
            if (end_restart) begin
                o_count <= '0; // period end, next period.
            end else begin
                o_count <= o_count + 1'b1;
            end
        end
    end

    // waveform and capture share the counter, only one may own it.
    a_one_mode: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        !(o_wave_en && o_cap_en)
    ) else $error("count_ctrl: wave and capture enabled together");

endmodule

`default_nettype wire

/* hdl/wave_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module wave_gen (
    input  wire                   i_clk,
    input  wire                   i_rst_n,
    input  wire                   i_wave_en,
    input  wire timer_pkg::cnt_t  i_count,
    input  wire timer_pkg::cnt_t  i_target0,
    input  wire timer_pkg::cnt_t  i_target1,
    input  wire timer_pkg::cnt_t  i_target2,
    input  wire                   i_keep_at_end,
    input  wire                   i_idle_level,
    output logic                  o_dout,
    output logic                  o_oen,
    output logic                  o_end
);

    logic hit0;
    logic hit1;
    logic hit2;

    assign hit0 = (i_count == i_target0);
    assign hit1 = (i_count == i_target1);
    assign hit2 = (i_count == i_target2);

    // period end goes to the counter control.
    assign o_end = i_wave_en & hit2;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_oen <= 1'b1; // released.
        end else begin
            o_oen <= ~i_wave_en;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_dout <= 1'b0;
        end else if (!i_wave_en) begin
            o_dout <= i_idle_level;
        end else if (hit0) begin
            o_dout <= 1'b0;   // fall point.
        end else if (hit1) begin
            o_dout <= 1'b1;   // rise point.
        end else if (hit2 && !i_keep_at_end) begin
            o_dout <= i_idle_level;
        end
    end

endmodule

`default_nettype wire

/* hdl/capture_bank.sv */
`timescale 1ns/1ns
`default_nettype none

module capture_bank (
    input  wire                            i_clk,
    input  wire                            i_rst_n,
    input  wire                            i_cap_en,
    input  wire                            i_clear,
    input  wire                            i_hit,
    input  wire timer_pkg::cnt_t           i_count,
    input  wire [timer_pkg::SLOT_NUM-1:0]  i_overwrite,
    input  wire                            i_rd_req,
    input  wire timer_pkg::slot_t          i_rd_slot,
    output logic [timer_pkg::SLOT_NUM-1:0] o_status,
    output logic                           o_rd_ack,
    output timer_pkg::cnt_t                o_rd_data
);

    localparam logic [timer_pkg::SLOT_NUM-1:0] ONE_HOT0 = 1;

    timer_pkg::cnt_t                slot_q [timer_pkg::SLOT_NUM];
    timer_pkg::slot_t               wr_idx;
    timer_pkg::slot_t               rd_idx_q;  // slot of the read in flight.
    logic [timer_pkg::SLOT_NUM-1:0] status_q;
    logic [timer_pkg::SLOT_NUM-1:0] set_mask;
    logic [timer_pkg::SLOT_NUM-1:0] clr_mask;
    logic                           cap_fire;
    logic                           wr_ok;
    logic                           rd_start;
    logic                           rd_done;

    assign cap_fire = i_cap_en & i_hit;
    // discard policy keeps a slot until it is read.
    assign wr_ok    = ~status_q[wr_idx] | i_overwrite[wr_idx];
    assign rd_start = i_rd_req & ~o_rd_ack;
    assign rd_done  = o_rd_ack & ~i_rd_req;

    assign set_mask = cap_fire ? (ONE_HOT0 << wr_idx) : '0;
    assign clr_mask = rd_done ? (ONE_HOT0 << rd_idx_q) : '0;

    assign o_status = status_q;

    // slots, ring index and status.
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < timer_pkg::SLOT_NUM; i++) begin
                slot_q[i] <= '0;
            end
            wr_idx   <= '0;
            status_q <= '0;
        end else if (i_clear) begin
            for (int i = 0; i < timer_pkg::SLOT_NUM; i++) begin
                slot_q[i] <= '0;
            end
            wr_idx   <= '0;
            status_q <= '0;
        end else begin
            if (cap_fire) begin
                if (wr_ok) begin
                    slot_q[wr_idx] <= i_count;
                end
                if (wr_idx == timer_pkg::slot_t'(timer_pkg::SLOT_NUM - 1)) begin
                    wr_idx <= '0;
                end else begin
                    wr_idx <= wr_idx + 1'b1;
                end
            end
            status_q <= (status_q & ~clr_mask) | set_mask; // capture wins.
        end
    end

    // four-phase read handshake.
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_rd_ack <= 1'b0;
            rd_idx_q <= '0;
        end else if (rd_start) begin
            o_rd_ack <= 1'b1;
            rd_idx_q <= i_rd_slot;
        end else if (rd_done) begin
            o_rd_ack <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (rd_start) begin
            if (int'(i_rd_slot) < timer_pkg::SLOT_NUM) begin
                o_rd_data <= slot_q[i_rd_slot];
            end else begin
                o_rd_data <= '0; // no such slot.
            end
        end
    end

    // the host holds req until it sees ack.
    a_ack_after_req: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        $rose(o_rd_ack) |-> i_rd_req
    ) else $error("capture_bank: ack raised without a request");

endmodule

`default_nettype wire

/* hdl/timer_top.sv */
`timescale 1ns/1ns
`default_nettype none

module timer_top (
    input  wire                             i_clk,
    input  wire                             i_rst_n,
    input  wire                             i_enable,
    input  wire                             i_extern_din_a,
    input  wire                             i_extern_din_b,
    input  wire [timer_pkg::INNER_NUM-1:0]  i_inner_din,
    input  wire                             i_soft_start,
    input  wire                             i_soft_stop,
    input  wire                             i_soft_clear,
    input  wire timer_pkg::sel_t            i_sel_start,
    input  wire timer_pkg::sel_t            i_sel_stop,
    input  wire timer_pkg::sel_t            i_sel_din0,
    input  wire timer_pkg::sel_t            i_sel_din1,
    input  wire timer_pkg::edge_t           i_edge_start,
    input  wire timer_pkg::edge_t           i_edge_stop,
    input  wire timer_pkg::edge_t           i_edge_din0,
    input  wire timer_pkg::edge_t           i_edge_din1,
    input  wire timer_pkg::mode_t           i_mode,
    input  wire timer_pkg::cnt_t            i_target_a0,
    input  wire timer_pkg::cnt_t            i_target_a1,
    input  wire timer_pkg::cnt_t            i_target_a2,
    input  wire timer_pkg::cnt_t            i_target_b0,
    input  wire timer_pkg::cnt_t            i_target_b1,
    input  wire timer_pkg::cnt_t            i_target_b2,
    input  wire                             i_stop_at_end_a,
    input  wire                             i_stop_at_end_b,
    input  wire                             i_keep_at_end_a,
    input  wire                             i_keep_at_end_b,
    input  wire                             i_idle_level_a,
    input  wire                             i_idle_level_b,
    input  wire [timer_pkg::SLOT_NUM-1:0]   i_overwrite_a,
    input  wire [timer_pkg::SLOT_NUM-1:0]   i_overwrite_b,
    input  wire                             i_rd_req_a,
    input  wire timer_pkg::slot_t           i_rd_slot_a,
    input  wire                             i_rd_req_b,
    input  wire timer_pkg::slot_t           i_rd_slot_b,
    output logic                            o_rd_ack_a,
    output timer_pkg::cnt_t                 o_rd_data_a,
    output logic                            o_rd_ack_b,
    output timer_pkg::cnt_t                 o_rd_data_b,
    output logic [timer_pkg::SLOT_NUM-1:0]  o_status_a,
    output logic [timer_pkg::SLOT_NUM-1:0]  o_status_b,
    output timer_pkg::cnt_t                 o_count,
    output logic                            o_running,
    output logic                            o_dout_a,
    output logic                            o_oen_a,
    output logic                            o_dout_b,
    output logic                            o_oen_b
);

    logic [timer_pkg::SRC_NUM-1:0] src;
    logic start_hit, stop_hit;
    logic din0_hit, din1_hit;
    logic wave_en, cap_en, clear;
    logic end_a, end_b;

    // source vector shared by all four selectors.
    assign src[timer_pkg::SRC_EXT_A] = i_extern_din_a;
    assign src[timer_pkg::SRC_EXT_B] = i_extern_din_b;
    assign src[timer_pkg::SRC_INNER0 +: timer_pkg::INNER_NUM] = i_inner_din;

    edge_select u_sel_start (.i_clk, .i_rst_n, .i_src(src), .i_sel(i_sel_start),
                             .i_edge(i_edge_start), .o_hit(start_hit));
    edge_select u_sel_stop (.i_clk, .i_rst_n, .i_src(src), .i_sel(i_sel_stop),
                            .i_edge(i_edge_stop), .o_hit(stop_hit));
    edge_select u_sel_din0 (.i_clk, .i_rst_n, .i_src(src), .i_sel(i_sel_din0),
                            .i_edge(i_edge_din0), .o_hit(din0_hit));
    edge_select u_sel_din1 (.i_clk, .i_rst_n, .i_src(src), .i_sel(i_sel_din1),
                            .i_edge(i_edge_din1), .o_hit(din1_hit));

    count_ctrl u_count_ctrl (
        .i_clk, .i_rst_n, .i_enable, .i_soft_start, .i_soft_stop, .i_soft_clear,
        .i_start_hit(start_hit), .i_stop_hit(stop_hit), .i_mode,
        .i_end_a(end_a), .i_end_b(end_b), .i_stop_at_end_a, .i_stop_at_end_b,
        .o_count, .o_running, .o_wave_en(wave_en), .o_cap_en(cap_en), .o_clear(clear)
    );

    wave_gen u_wave_a (
        .i_clk, .i_rst_n, .i_wave_en(wave_en), .i_count(o_count),
        .i_target0(i_target_a0), .i_target1(i_target_a1), .i_target2(i_target_a2),
        .i_keep_at_end(i_keep_at_end_a), .i_idle_level(i_idle_level_a),
        .o_dout(o_dout_a), .o_oen(o_oen_a), .o_end(end_a)
    );
    wave_gen u_wave_b (
        .i_clk, .i_rst_n, .i_wave_en(wave_en), .i_count(o_count),
        .i_target0(i_target_b0), .i_target1(i_target_b1), .i_target2(i_target_b2),
        .i_keep_at_end(i_keep_at_end_b), .i_idle_level(i_idle_level_b),
        .o_dout(o_dout_b), .o_oen(o_oen_b), .o_end(end_b)
    );

    capture_bank u_cap_a (
        .i_clk, .i_rst_n, .i_cap_en(cap_en), .i_clear(clear), .i_hit(din0_hit),
        .i_count(o_count), .i_overwrite(i_overwrite_a), .i_rd_req(i_rd_req_a),
        .i_rd_slot(i_rd_slot_a), .o_status(o_status_a), .o_rd_ack(o_rd_ack_a),
        .o_rd_data(o_rd_data_a)
    );
    capture_bank u_cap_b (
        .i_clk, .i_rst_n, .i_cap_en(cap_en), .i_clear(clear), .i_hit(din1_hit),
        .i_count(o_count), .i_overwrite(i_overwrite_b), .i_rd_req(i_rd_req_b),
        .i_rd_slot(i_rd_slot_b), .o_status(o_status_b), .o_rd_ack(o_rd_ack_b),
        .o_rd_data(o_rd_data_b)
    );

endmodule

`default_nettype wire

/* dv/timer_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module timer_tb;

    localparam int TIMEOUT   = 200;  // cycles allowed for any one wait.
    localparam int DRIVE_DLY = 5;
    localparam int LINE      = 1;    // inner line used as capture source.

    logic i_clk, i_rst_n, i_enable, i_extern_din_a, i_extern_din_b;
    logic i_soft_start, i_soft_stop, i_soft_clear;
    logic [timer_pkg::INNER_NUM-1:0] i_inner_din;
    timer_pkg::sel_t  i_sel_start, i_sel_stop, i_sel_din0, i_sel_din1;
    timer_pkg::edge_t i_edge_start, i_edge_stop, i_edge_din0, i_edge_din1;
    timer_pkg::mode_t i_mode;
    timer_pkg::cnt_t  i_target_a0, i_target_a1, i_target_a2;
    timer_pkg::cnt_t  i_target_b0, i_target_b1, i_target_b2;
    logic i_stop_at_end_a, i_stop_at_end_b, i_keep_at_end_a, i_keep_at_end_b;
    logic i_idle_level_a, i_idle_level_b;
    logic [timer_pkg::SLOT_NUM-1:0] i_overwrite_a, i_overwrite_b, o_status_a, o_status_b;
    logic i_rd_req_a, i_rd_req_b, o_rd_ack_a, o_rd_ack_b;
    timer_pkg::slot_t i_rd_slot_a, i_rd_slot_b;
    timer_pkg::cnt_t  o_rd_data_a, o_rd_data_b, o_count;
    logic o_running, o_dout_a, o_oen_a, o_dout_b, o_oen_b;

    logic [31:0] rng = 32'h58c6_ace2;
    int          cyc = 0;
    int          base;            // cycle at which the counter read zero.
    int          ring;            // expected write index of both banks.
    int          n_checks = 0;
    int          n_errors = 0;
    logic [31:0] caps [4];
    logic [31:0] caps_b [4];
    int          falls [4];
    string       name_q [$];
    logic [31:0] exp_q [$];
    logic [31:0] act_q [$];
    string       cmp_name;
    logic [31:0] cmp_exp;
    logic [31:0] cmp_act;

    timer_top u_timer_top (.*);

    initial begin
        i_clk = 1'b0;
        forever #50 i_clk = ~i_clk;
    end

    always @(posedge i_clk) cyc <= cyc + 1;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic int next_rand(input int range);
        rng = xorshift32(rng);
        return int'(rng % range);
    endfunction

    // slot contents after n captures into a fresh bank.
    function automatic logic [31:0] expected_slot(input logic [31:0] c [4], input int n,
                                                  input logic [2:0] ow, input int slot);
        logic [31:0] slots [3];
        logic [2:0]  full;
        int          idx;
        full = '0;
        idx  = 0;
        for (int s = 0; s < 3; s++) begin
            slots[s] = '0;
        end
        for (int k = 0; k < n; k++) begin
            if (!full[idx] || ow[idx]) begin
                slots[idx] = c[k];
            end
            full[idx] = 1'b1;
            idx = (idx + 1) % 3;
        end
        return slots[slot];
    endfunction

    // {high time, period} of a restarting waveform.
    function automatic logic [63:0] wave_durations(input logic [31:0] t0, t1, t2);
        logic [31:0] high;
        high = t0 - t1;              // rises at t1, falls at t0.
        return {high, t2 + 32'd1};   // count runs 0 to t2.
    endfunction

    function automatic logic read_ack(input logic bank_b);
        return bank_b ? o_rd_ack_b : o_rd_ack_a;
    endfunction

    task automatic step();
        @(posedge i_clk);
        #DRIVE_DLY;
    endtask

    task automatic expect_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        name_q.push_back(name);
        exp_q.push_back(exp);
        act_q.push_back(act);
    endtask

    task automatic timeout_fail(input string what);
        n_errors++;
        $display("timeout while waiting for %s", what);
        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        $display("Testbench failed");
        $finish;
    endtask

    task automatic wait_running(input logic level);
        int n;
        n = 0;
        while (o_running !== level) begin
            step();
            n++;
            if (n > TIMEOUT) begin
                timeout_fail("o_running");
            end
        end
    endtask

    task automatic wait_ack(input logic bank_b, input logic level);
        int n;
        n = 0;
        while (read_ack(bank_b) !== level) begin
            step();
            n++;
            if (n > TIMEOUT) begin
                timeout_fail("read ack");
            end
        end
    endtask

    // cycles for which dout a stays at one level.
    task automatic run_length(input logic level, output int len);
        len = 0;
        while (o_dout_a === level) begin
            len++;
            step();
            if (len > TIMEOUT) begin
                timeout_fail("dout a to change");
            end
        end
    endtask

    // bank a takes the falling edge, bank b the rising one.
    task automatic capture_pulse(input int low_cycles, output logic [31:0] cap,
                                 output logic [31:0] cap_b, output int fall);
        logic [2:0] old;
        logic [2:0] old_b;
        logic [2:0] want;
        old   = o_status_a;
        old_b = o_status_b;
        want  = 3'b001 << ring;
        i_inner_din[LINE] = 1'b1;
        cap_b = cyc - base + 1;      // hit lands two edges later.
        repeat (3) step();
        expect_val("status a after rising edge", old, o_status_a);
        expect_val("status b after rising edge", old_b | want, o_status_b);
        i_inner_din[LINE] = 1'b0;
        cap  = cyc - base + 1;
        fall = cyc;
        ring = (ring + 1) % 3;
        repeat (3) step();
        expect_val("status a after falling edge", old | want, o_status_a);
        expect_val("status b after falling edge", old_b | want, o_status_b);
        repeat (low_cycles) step();
    endtask

    task automatic read_slot(input logic bank_b, input int slot, output logic [31:0] data);
        expect_val("ack low before req", 0, read_ack(bank_b));
        if (bank_b) begin
            i_rd_slot_b = timer_pkg::slot_t'(slot);
            i_rd_req_b  = 1'b1;
        end else begin
            i_rd_slot_a = timer_pkg::slot_t'(slot);
            i_rd_req_a  = 1'b1;
        end
        wait_ack(bank_b, 1'b1);
        data = bank_b ? o_rd_data_b : o_rd_data_a;
        step();
        expect_val("read data held with ack", data, bank_b ? o_rd_data_b : o_rd_data_a);
        if (bank_b) begin
            i_rd_req_b = 1'b0;
        end else begin
            i_rd_req_a = 1'b0;
        end
        wait_ack(bank_b, 1'b0);
        expect_val("status cleared by read", 0,
                   bank_b ? o_status_b[slot] : o_status_a[slot]);
    endtask

    always @(posedge i_clk) begin
        while (exp_q.size() > 0) begin
            cmp_name = name_q.pop_front();
            cmp_exp  = exp_q.pop_front();
            cmp_act  = act_q.pop_front();
            n_checks++;
            assert (cmp_act === cmp_exp) else begin
                n_errors++;
                $display("FAIL %s: expected 0x%0h, actual 0x%0h", cmp_name, cmp_exp, cmp_act);
            end
        end
    end

    initial begin
        logic [31:0] prev;
        logic [31:0] t0, t1, t2, b2;
        logic [63:0] ref_wave;
        logic [31:0] data [3];
        logic [31:0] data_b [3];
        int          hi, lo, skip;
        i_rst_n = 1'b0;
        i_enable = 1'b0;
        {i_extern_din_a, i_extern_din_b, i_inner_din} = '0;
        {i_soft_start, i_soft_stop, i_soft_clear} = '0;
        {i_sel_start, i_sel_stop, i_sel_din0, i_sel_din1} = '1;  // constant low.
        i_edge_start = timer_pkg::EDGE_NONE;
        i_edge_stop  = timer_pkg::EDGE_NONE;
        i_edge_din0  = timer_pkg::EDGE_NONE;
        i_edge_din1  = timer_pkg::EDGE_NONE;
        i_mode = timer_pkg::MODE_WAVE;
        {i_target_a0, i_target_a1, i_target_a2} = '1;
        {i_target_b0, i_target_b1, i_target_b2} = '1;
        {i_stop_at_end_a, i_stop_at_end_b, i_keep_at_end_a, i_keep_at_end_b} = '0;
        {i_idle_level_a, i_idle_level_b} = '0;
        {i_overwrite_a, i_overwrite_b} = '0;
        {i_rd_req_a, i_rd_req_b, i_rd_slot_a, i_rd_slot_b} = '0;
        repeat (16) step();
        i_rst_n  = 1'b1;
        i_enable = 1'b1;
        step();

        i_soft_start = ~i_soft_start;
        wait_running(1'b1);
        prev = 0;                    // counter left reset.
        expect_val("count at start", prev, o_count);
        repeat (8) begin
            step();
            prev = prev + 1;
            expect_val("count increment", prev, o_count);
        end
        i_soft_stop = ~i_soft_stop;
        wait_running(1'b0);
        repeat (5) begin
            step();
            expect_val("count held after stop", prev, o_count);
        end
        i_soft_clear = ~i_soft_clear;
        step();
        expect_val("count after clear", 0, o_count);

        // waveform on channel a, started from pin a.
        t1 = 2 + next_rand(8);
        t0 = t1 + 2 + next_rand(10);
        t2 = t0 + 2 + next_rand(10);
        i_target_a0    = t0;
        i_target_a1    = t1;
        i_target_a2    = t2;
        i_idle_level_b = 1'b1;       // channel b has no compare hits.
        i_sel_start    = timer_pkg::sel_t'(timer_pkg::SRC_EXT_A);
        i_edge_start   = timer_pkg::EDGE_RISE;
        step();
        i_extern_din_a = 1'b1;
        wait_running(1'b1);
        step();
        expect_val("oen a while running", 0, o_oen_a);
        expect_val("oen b while running", 0, o_oen_b);
        expect_val("dout b at idle level", 1, o_dout_b);
        run_length(1'b0, skip);
        run_length(1'b1, hi);
        run_length(1'b0, lo);
        ref_wave = wave_durations(t0, t1, t2);
        expect_val("dout a high time", ref_wave[63:32], hi);
        expect_val("dout a period", ref_wave[31:0], hi + lo);

        b2 = 1 + next_rand(int'(t2) - 1);
        i_target_b2     = b2;
        i_stop_at_end_b = 1'b1;
        wait_running(1'b0);
        expect_val("count held at end of b", b2, o_count);
        step();
        expect_val("oen a released after stop", 1, o_oen_a);
        expect_val("oen b released after stop", 1, o_oen_b);

        // capture on both edges of an inner line.
        i_stop_at_end_b = 1'b0;
        i_target_b2     = '1;
        i_extern_din_a  = 1'b0;
        i_mode          = timer_pkg::MODE_CAPTURE;
        i_sel_din0      = timer_pkg::sel_t'(timer_pkg::SRC_INNER0 + LINE);
        i_edge_din0     = timer_pkg::EDGE_FALL;
        i_sel_din1      = timer_pkg::sel_t'(timer_pkg::SRC_INNER0 + LINE);
        i_edge_din1     = timer_pkg::EDGE_RISE;
        i_soft_clear    = ~i_soft_clear;
        ring            = 0;
        step();
        i_soft_start = ~i_soft_start;
        wait_running(1'b1);
        base = cyc;                  // count still zero here.
        for (int k = 0; k < 3; k++) begin
            capture_pulse(2 + next_rand(12), caps[k], caps_b[k], falls[k]);
        end
        for (int k = 0; k < 3; k++) begin
            read_slot(1'b0, k, data[k]);
            expect_val("capture slot value", expected_slot(caps, 3, 3'b000, k), data[k]);
            if (k > 0) begin
                expect_val("capture spacing", falls[k] - falls[k-1], data[k] - data[k-1]);
            end
            read_slot(1'b1, k, data_b[k]);
            expect_val("capture slot value b",
                       expected_slot(caps_b, 3, 3'b000, k), data_b[k]);
        end

        // discard first, then overwrite.
        for (int pol = 0; pol < 2; pol++) begin
            i_overwrite_a = (pol == 1) ? 3'b111 : 3'b000;
            i_overwrite_b = i_overwrite_a;
            i_soft_clear  = ~i_soft_clear;
            ring          = 0;
            step();
            base = cyc;              // cleared at this edge.
            for (int k = 0; k < 4; k++) begin
                capture_pulse(2 + next_rand(6), caps[k], caps_b[k], falls[k]);
            end
            for (int k = 0; k < 3; k++) begin
                read_slot(1'b0, k, data[k]);
                expect_val("overflow slot value",
                           expected_slot(caps, 4, i_overwrite_a, k), data[k]);
                read_slot(1'b1, k, data_b[k]);
                expect_val("overflow slot value b",
                           expected_slot(caps_b, 4, i_overwrite_b, k), data_b[k]);
            end
        end

        step();
        step();
        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* timer_top.f */
hdl/timer_pkg.sv
hdl/edge_select.sv
hdl/count_ctrl.sv
hdl/wave_gen.sv
hdl/capture_bank.sv
hdl/timer_top.sv
dv/timer_tb.sv

/* Bender.yml */
package:
  name: timer_top

sources:
  - hdl/timer_pkg.sv
  - hdl/edge_select.sv
  - hdl/count_ctrl.sv
  - hdl/wave_gen.sv
  - hdl/capture_bank.sv
  - hdl/timer_top.sv
  - target: simulation
    files:
      - dv/timer_tb.sv
